// File: source/framer_pkg.sv
// Shared widths and bus structs for the CHDR Ethernet framer
// Framer state encoding
// Ethernet, IPv4 and UDP header constants
// Settings register map: region codes, source registers, table word selects

package framer_pkg;

  // Address and field widths
  typedef logic [47:0] mac_addr_t;
  typedef logic [31:0] ip_addr_t;
  typedef logic [15:0] udp_port_t;
  typedef logic [7:0]  sid_t;
  typedef logic [3:0]  local_addr_t;
  typedef logic [15:0] len_t;
  typedef logic [63:0] word_t;
  typedef logic [11:0] set_addr_t;

  // Source addresses used in every frame
  typedef struct packed {
    mac_addr_t mac;
    ip_addr_t  ip;
    udp_port_t udp;
  } src_cfg_t;

  // One destination table entry
  typedef struct packed {
    ip_addr_t  ip;
    udp_port_t udp;
    mac_addr_t mac;
  } dest_entry_t;

  // Single 32-bit word write into a destination table
  typedef struct packed {
    logic [7:0]  index;
    logic [1:0]  word_sel;
    logic [31:0] data;
    logic        valid;
  } table_wr_t;

  typedef enum logic [3:0] {
    IDLE,
    LOOKUP,
    HDR0,
    HDR1,
    HDR2,
    HDR3,
    HDR4,
    HDR5,
    PAYLOAD
  } framer_state_t;

  // Settings regions, taken from address bits 11:8
  localparam logic [3:0] REGION_SRC    = 4'd0;
  localparam logic [3:0] REGION_REMOTE = 4'd1;
  localparam logic [3:0] REGION_LOCAL  = 4'd4;

  // Registers inside REGION_SRC
  localparam logic [7:0] REG_SRC_MAC_HI = 8'd0;
  localparam logic [7:0] REG_SRC_MAC_LO = 8'd1;
  localparam logic [7:0] REG_SRC_IP     = 8'd2;
  localparam logic [7:0] REG_SRC_UDP    = 8'd3;

  // Table word selects
  localparam logic [1:0] WSEL_IP         = 2'd0;
  localparam logic [1:0] WSEL_UDP_MAC_HI = 2'd1;
  localparam logic [1:0] WSEL_MAC_LO     = 2'd2;

  // Header constants
  localparam logic [15:0] ETH_TYPE_IPV4  = 16'h0800;
  localparam logic [15:0] IP_VER_IHL_TOS = 16'h4500;
  localparam logic [15:0] IP_FLAGS_DF    = 16'h4000;
  localparam logic [15:0] IP_TTL_PROTO   = 16'h1011;
  localparam len_t        IP_HDR_BYTES   = 16'd20;
  localparam len_t        UDP_HDR_BYTES  = 16'd8;

endpackage

// File: source/framer_settings.sv
// Settings bus decoder for the framer
// Holds the source MAC, IP and UDP port registers
// Turns table-region writes into local and remote table write commands

`timescale 1ns/1ns

module framer_settings (
  input  logic                  clk,
  input  logic                  arst_n,
  input  logic                  set_stb,
  input  framer_pkg::set_addr_t set_addr,
  input  logic [31:0]           set_data,
  output framer_pkg::src_cfg_t  src_cfg,
  output framer_pkg::table_wr_t local_wr,
  output framer_pkg::table_wr_t remote_wr
);

  import framer_pkg::*;

  logic [3:0] region;
  logic [7:0] reg_num;
  logic [3:0] local_sel;
  logic       local_hit;

  assign region  = set_addr[11:8];
  assign reg_num = set_addr[7:0];

  // Local table uses three consecutive regions, one per word
  assign local_sel = region - REGION_LOCAL;
  assign local_hit = (region >= REGION_LOCAL) && (local_sel < 4'd3);

  // Source registers, MAC split over two writes
  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      src_cfg <= '0;
    end
    else if (set_stb && (region == REGION_SRC))
    begin
      case (reg_num)
        REG_SRC_MAC_HI: src_cfg.mac[47:32] <= set_data[15:0];
        REG_SRC_MAC_LO: src_cfg.mac[31:0]  <= set_data;
        REG_SRC_IP:     src_cfg.ip         <= set_data;
        REG_SRC_UDP:    src_cfg.udp        <= set_data[15:0];
        default:        src_cfg            <= src_cfg;
      endcase
    end
  end

  // Local table: word from region code, full 8-bit index
  always_comb
  begin
    local_wr.index    = reg_num;
    local_wr.word_sel = local_sel[1:0];
    local_wr.data     = set_data;
    local_wr.valid    = set_stb && local_hit;
  end

  // Remote table: word in bits 7:6, index in bits 5:0
  always_comb
  begin
    remote_wr.index    = {2'b00, reg_num[5:0]};
    remote_wr.word_sel = reg_num[7:6];
    remote_wr.data     = set_data;
    remote_wr.valid    = set_stb && (region == REGION_REMOTE) && (reg_num[7:6] != 2'd3);
  end

  // A single bus write never lands in both tables
  wr_exclusive_a : assert property (
    @(posedge clk) disable iff (!arst_n)
    !(local_wr.valid && remote_wr.valid)
  );

endmodule

// File: source/dest_table.sv
// Destination table of three-word entries (IP, UDP plus upper MAC, lower MAC)
// Synchronous word write port, registered full-entry read port

`timescale 1ns/1ns

module dest_table #(
  parameter int INDEX_WIDTH = 8
) (
  input  logic                    clk,
  input  framer_pkg::table_wr_t   wr,
  input  logic [INDEX_WIDTH-1:0]  rd_index,
  output framer_pkg::dest_entry_t rd_entry
);

  import framer_pkg::*;

  localparam int DEPTH = 2 ** INDEX_WIDTH;

  logic [31:0]            ip_mem      [DEPTH];
  logic [31:0]            udp_mac_mem [DEPTH];
  logic [31:0]            mac_lo_mem  [DEPTH];
  logic [INDEX_WIDTH-1:0] wr_index;

  // Upper index bits beyond the table depth are dropped
  assign wr_index = wr.index[INDEX_WIDTH-1:0];

  always_ff @(posedge clk)
  begin
    if (wr.valid)
    begin
      case (wr.word_sel)
        WSEL_IP:         ip_mem[wr_index]      <= wr.data;
        WSEL_UDP_MAC_HI: udp_mac_mem[wr_index] <= wr.data;
        WSEL_MAC_LO:     mac_lo_mem[wr_index]  <= wr.data;
        default:         ;
      endcase
    end
  end

  // All three words read at once into one entry
  always_ff @(posedge clk)
  begin
    rd_entry.ip  <= ip_mem[rd_index];
    rd_entry.udp <= udp_mac_mem[rd_index][31:16];
    rd_entry.mac <= {udp_mac_mem[rd_index][15:0], mac_lo_mem[rd_index]};
  end

endmodule

// File: source/ip_checksum.sv
// IPv4 header checksum over the ten header halfwords
// Ones' complement sum with carry folding, inverted and registered

`timescale 1ns/1ns

module ip_checksum (
  input  logic                 clk,
  input  logic                 arst_n,
  input  framer_pkg::len_t     hdr_ip_len,
  input  framer_pkg::ip_addr_t hdr_ip_src,
  input  framer_pkg::ip_addr_t hdr_ip_dst,
  output logic [15:0]          checksum
);

  import framer_pkg::*;

  logic [19:0] sum_full;
  logic [16:0] sum_fold;
  logic [15:0] sum_final;

  // Ident and the checksum field itself add zero
  assign sum_full = 20'(IP_VER_IHL_TOS) + 20'(hdr_ip_len) + 20'(IP_FLAGS_DF)
                  + 20'(IP_TTL_PROTO)
                  + 20'(hdr_ip_src[31:16]) + 20'(hdr_ip_src[15:0])
                  + 20'(hdr_ip_dst[31:16]) + 20'(hdr_ip_dst[15:0]);

  // Two folds absorb every carry out of bit 15
  assign sum_fold  = 17'(sum_full[15:0]) + 17'(sum_full[19:16]);
  assign sum_final = sum_fold[15:0] + 16'(sum_fold[16]);

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      checksum <= '0;
    end
    else
    begin
      checksum <= ~sum_final;
    end
  end

endmodule

// File: source/chdr_eth_framer.sv
// CHDR to Ethernet/IPv4/UDP framing FSM
// Captures sid, local address and length from the CHDR header word
// Selects local or remote destination, builds six header words,
// then passes the CHDR packet through unchanged

`timescale 1ns/1ns

module chdr_eth_framer (
  input  logic                     clk,
  input  logic                     arst_n,
  input  logic                     clear,
  input  framer_pkg::src_cfg_t     src_cfg,
  input  framer_pkg::dest_entry_t  local_entry,
  input  framer_pkg::dest_entry_t  remote_entry,
  input  logic [15:0]              checksum,
  output framer_pkg::sid_t         sid,
  output framer_pkg::local_addr_t  local_addr,
  output framer_pkg::len_t         hdr_ip_len,
  output framer_pkg::ip_addr_t     hdr_ip_dst,
  input  framer_pkg::word_t        in_tdata,
  input  logic                     in_tlast,
  input  logic                     in_tvalid,
  output logic                     in_tready,
  output framer_pkg::word_t        out_tdata,
  output logic [3:0]               out_tuser,
  output logic                     out_tlast,
  output logic                     out_tvalid,
  input  logic                     out_tready
);

  import framer_pkg::*;

  framer_state_t state;
  framer_state_t state_next;
  len_t          pkt_len;
  len_t          udp_len;
  dest_entry_t   dest;
  logic          use_local;
  logic          in_hdr;

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      state <= IDLE;
    end
    else if (clear)
    begin
      state <= IDLE;
    end
    else
    begin
      state <= state_next;
    end
  end

  always_comb
  begin
    state_next = state;
    case (state)
      IDLE:
        if (in_tvalid)
          state_next = LOOKUP;
      // Tables are addressed here, entries ready in HDR0
      LOOKUP: state_next = HDR0;
      HDR0:
        if (out_tready)
          state_next = HDR1;
      HDR1:
        if (out_tready)
          state_next = HDR2;
      HDR2:
        if (out_tready)
          state_next = HDR3;
      HDR3:
        if (out_tready)
          state_next = HDR4;
      HDR4:
        if (out_tready)
          state_next = HDR5;
      HDR5:
        if (out_tready)
          state_next = PAYLOAD;
      PAYLOAD:
        if (in_tvalid && out_tready && in_tlast)
          state_next = IDLE;
      default: state_next = IDLE;
    endcase
  end

  // First word is only looked at, not consumed, while idle
  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      sid        <= '0;
      local_addr <= '0;
      pkt_len    <= '0;
    end
    else if ((state == IDLE) && in_tvalid)
    begin
      sid        <= in_tdata[7:0];
      local_addr <= in_tdata[11:8];
      pkt_len    <= in_tdata[47:32];
    end
  end

  // Local addresses 0 and 1 route through the sid-indexed table
  assign use_local = (local_addr == 4'd0) || (local_addr == 4'd1);
  assign dest      = use_local ? local_entry : remote_entry;

  assign hdr_ip_dst = dest.ip;
  assign hdr_ip_len = pkt_len + IP_HDR_BYTES + UDP_HDR_BYTES;
  assign udp_len    = pkt_len + UDP_HDR_BYTES;

  assign in_hdr = (state >= HDR0) && (state <= HDR5);

  assign in_tready  = (state == PAYLOAD) ? out_tready : 1'b0;
  assign out_tvalid = (state == PAYLOAD) ? in_tvalid : in_hdr;
  assign out_tlast  = (state == PAYLOAD) && in_tlast;
  // Byte count of the last word, 0 for a full word
  assign out_tuser  = ((state == PAYLOAD) && in_tlast) ? {1'b0, pkt_len[2:0]} : 4'd0;

  always_comb
  begin
    case (state)
      HDR0:    out_tdata = {48'h0, dest.mac[47:32]};
      HDR1:    out_tdata = {dest.mac[31:0], src_cfg.mac[47:16]};
      HDR2:    out_tdata = {src_cfg.mac[15:0], ETH_TYPE_IPV4, IP_VER_IHL_TOS, hdr_ip_len};
      HDR3:    out_tdata = {16'h0, IP_FLAGS_DF, IP_TTL_PROTO, checksum};
      HDR4:    out_tdata = {src_cfg.ip, dest.ip};
      HDR5:    out_tdata = {src_cfg.udp, dest.udp, udp_len, 16'h0};
      default: out_tdata = in_tdata;
    endcase
  end

  // Input is only drawn while the packet body streams
  ready_in_payload_a : assert property (
    @(posedge clk) disable iff (!arst_n)
    in_tready |-> (state == PAYLOAD)
  );

  // A stalled output word is not withdrawn
  valid_held_a : assert property (
    @(posedge clk) disable iff (!arst_n || clear)
    (out_tvalid && !out_tready) |=> out_tvalid
  );

endmodule

// File: source/eth_framer_top.sv
// Top level of the CHDR Ethernet framer
// Settings decoder, local and remote destination tables,
// IPv4 header checksum and framing FSM

`timescale 1ns/1ns

module eth_framer_top #(
  parameter int LOCAL_INDEX_WIDTH  = 8,
  parameter int REMOTE_INDEX_WIDTH = 4
) (
  input  logic                  clk,
  input  logic                  arst_n,
  input  logic                  clear,
  input  logic                  set_stb,
  input  framer_pkg::set_addr_t set_addr,
  input  logic [31:0]           set_data,
  input  framer_pkg::word_t     in_tdata,
  input  logic                  in_tlast,
  input  logic                  in_tvalid,
  output logic                  in_tready,
  output framer_pkg::word_t     out_tdata,
  output logic [3:0]            out_tuser,
  output logic                  out_tlast,
  output logic                  out_tvalid,
  input  logic                  out_tready
);

  import framer_pkg::*;

  src_cfg_t    src_cfg;
  table_wr_t   local_wr;
  table_wr_t   remote_wr;
  dest_entry_t local_entry;
  dest_entry_t remote_entry;
  sid_t        sid;
  local_addr_t local_addr;
  len_t        hdr_ip_len;
  ip_addr_t    hdr_ip_dst;
  logic [15:0] checksum;

  framer_settings i_settings (
    .clk       (clk),
    .arst_n    (arst_n),
    .set_stb   (set_stb),
    .set_addr  (set_addr),
    .set_data  (set_data),
    .src_cfg   (src_cfg),
    .local_wr  (local_wr),
    .remote_wr (remote_wr)
  );

  // Local table follows the stream ID
  dest_table #(
    .INDEX_WIDTH (LOCAL_INDEX_WIDTH)
  ) i_local_table (
    .clk      (clk),
    .wr       (local_wr),
    .rd_index (sid[LOCAL_INDEX_WIDTH-1:0]),
    .rd_entry (local_entry)
  );

  // Remote table follows the local address
  dest_table #(
    .INDEX_WIDTH (REMOTE_INDEX_WIDTH)
  ) i_remote_table (
    .clk      (clk),
    .wr       (remote_wr),
    .rd_index (local_addr[REMOTE_INDEX_WIDTH-1:0]),
    .rd_entry (remote_entry)
  );

  ip_checksum i_checksum (
    .clk        (clk),
    .arst_n     (arst_n),
    .hdr_ip_len (hdr_ip_len),
    .hdr_ip_src (src_cfg.ip),
    .hdr_ip_dst (hdr_ip_dst),
    .checksum   (checksum)
  );

  chdr_eth_framer i_framer (
    .clk          (clk),
    .arst_n       (arst_n),
    .clear        (clear),
    .src_cfg      (src_cfg),
    .local_entry  (local_entry),
    .remote_entry (remote_entry),
    .checksum     (checksum),
    .sid          (sid),
    .local_addr   (local_addr),
    .hdr_ip_len   (hdr_ip_len),
    .hdr_ip_dst   (hdr_ip_dst),
    .in_tdata     (in_tdata),
    .in_tlast     (in_tlast),
    .in_tvalid    (in_tvalid),
    .in_tready    (in_tready),
    .out_tdata    (out_tdata),
    .out_tuser    (out_tuser),
    .out_tlast    (out_tlast),
    .out_tvalid   (out_tvalid),
    .out_tready   (out_tready)
  );

endmodule

// File: verification/tb_framer_tasks.svh
// Testbench helpers for the CHDR Ethernet framer
// Value check, settings write, stream driver, ready driver, frame collector
// Reference IPv4 checksum and reference frame builder

`ifndef TB_FRAMER_TASKS_SVH
`define TB_FRAMER_TASKS_SVH

task automatic check_value(input string name, input logic [63:0] actual,
                           input logic [63:0] expected);
  if (actual !== expected)
  begin
    stop_on_error($sformatf("FAILED %s: got 0x%h, expected 0x%h", name, actual, expected));
  end
endtask

// One strobe cycle, entered and left 1 ns after a rising edge
task automatic write_setting(input logic [11:0] addr, input logic [31:0] data);
  set_stb  = 1'b1;
  set_addr = addr;
  set_data = data;
  @(posedge clk);
  #1;
  set_stb = 1'b0;
endtask

// Streams every queued input word, holding each until in_tready
task automatic send_packet();
  int idx;
  int waited;
  idx = 0;
  while (idx < in_words.size())
  begin
    in_tdata  = in_words[idx];
    in_tlast  = in_lasts[idx];
    in_tvalid = 1'b1;
    waited    = 0;
    @(negedge clk);
    while (!in_tready)
    begin
      waited++;
      if (waited > TIMEOUT_CYCLES)
        stop_on_error("Timeout: input word was never accepted by the framer");
      @(negedge clk);
    end
    @(posedge clk);
    #1;
    idx++;
  end
  in_tvalid = 1'b0;
  in_tlast  = 1'b0;
endtask

task automatic drive_ready(input bit backpressure);
  while (!streams_done)
  begin
    @(posedge clk);
    #1;
    if (backpressure)
      out_tready = ($random(seed) & 3) != 0;
    else
      out_tready = 1'b1;
  end
endtask

// Samples at the falling edge, where outputs are settled
task automatic collect_frame(input int n_frames);
  int frames;
  int idle;
  frames = 0;
  idle   = 0;
  while (frames < n_frames)
  begin
    @(negedge clk);
    check_value("in_tready with out_tready low", in_tready && !out_tready, 0);
    if (out_tvalid && out_tready)
    begin
      got_data.push_back(out_tdata);
      got_user.push_back(out_tuser);
      got_last.push_back(out_tlast);
      if (out_tlast)
        frames++;
      idle = 0;
    end
    else
    begin
      idle++;
      if (idle > TIMEOUT_CYCLES)
        stop_on_error("Timeout: no output word arrived from the framer");
    end
  end
endtask

function automatic logic [15:0] ip_header_checksum(input logic [15:0] ip_len,
                                                   input logic [31:0] ip_src,
                                                   input logic [31:0] ip_dst);
  logic [31:0] sum;
  sum = 32'h4500 + ip_len + 32'h4000 + 32'h1011 + ip_src[31:16] + ip_src[15:0]
      + ip_dst[31:16] + ip_dst[15:0];
  while (sum[31:16] != 16'h0)
    sum = {16'h0, sum[15:0]} + {16'h0, sum[31:16]};
  return ~sum[15:0];
endfunction

// Six header words, then the CHDR words as queued
task automatic expect_frame(input logic [15:0] len, input logic [3:0] laddr,
                            input logic [7:0] sid, input int first, input int n_words);
  logic [95:0] dest;
  logic [15:0] ip_len;
  logic        last;
  dest   = (laddr < 4'd2) ? loc_tab[sid] : rem_tab[laddr];
  ip_len = len + 16'd28;
  exp_data.push_back({48'h0, dest[47:32]});
  exp_data.push_back({dest[31:0], src_mac[47:16]});
  exp_data.push_back({src_mac[15:0], 16'h0800, 16'h4500, ip_len});
  exp_data.push_back({16'h0, 16'h4000, 16'h1011,
                      ip_header_checksum(ip_len, src_ip, dest[95:64])});
  exp_data.push_back({src_ip, dest[95:64]});
  exp_data.push_back({src_udp, dest[63:48], len + 16'd8, 16'h0});
  repeat (6)
  begin
    exp_user.push_back(4'd0);
    exp_last.push_back(1'b0);
  end
  for (int i = 0; i < n_words; i++)
  begin
    last = (i == n_words - 1);
    exp_data.push_back(in_words[first + i]);
    exp_user.push_back(last ? 4'(len % 8) : 4'd0);
    exp_last.push_back(last);
  end
endtask

`endif

// File: verification/tb_eth_framer_top.sv
// Testbench top for the CHDR Ethernet framer
// Clock, reset, DUT instance, reference copies of the settings
// Directed tests for local, remote, back-pressure and clear

`timescale 1ns/1ns

module tb_eth_framer_top;

  localparam int TIMEOUT_CYCLES = 2000;

  logic        clk;
  logic        arst_n;
  logic        clear;
  logic        set_stb;
  logic [11:0] set_addr;
  logic [31:0] set_data;
  logic [63:0] in_tdata;
  logic        in_tlast;
  logic        in_tvalid;
  logic        in_tready;
  logic [63:0] out_tdata;
  logic [3:0]  out_tuser;
  logic        out_tlast;
  logic        out_tvalid;
  logic        out_tready;

  // Reference settings, table entries packed as {ip, udp, mac}
  logic [47:0] src_mac;
  logic [31:0] src_ip;
  logic [15:0] src_udp;
  logic [95:0] loc_tab [256];
  logic [95:0] rem_tab [16];

  logic [63:0] in_words [$];
  logic        in_lasts [$];
  logic [63:0] exp_data [$];
  logic [3:0]  exp_user [$];
  logic        exp_last [$];
  logic [63:0] got_data [$];
  logic [3:0]  got_user [$];
  logic        got_last [$];
  logic        streams_done;
  integer      seed;

  `include "tb_framer_tasks.svh"

  always #4 clk = ~clk;

  eth_framer_top #(
    .LOCAL_INDEX_WIDTH  (8),
    .REMOTE_INDEX_WIDTH (4)
  ) i_dut (
    .clk        (clk),
    .arst_n     (arst_n),
    .clear      (clear),
    .set_stb    (set_stb),
    .set_addr   (set_addr),
    .set_data   (set_data),
    .in_tdata   (in_tdata),
    .in_tlast   (in_tlast),
    .in_tvalid  (in_tvalid),
    .in_tready  (in_tready),
    .out_tdata  (out_tdata),
    .out_tuser  (out_tuser),
    .out_tlast  (out_tlast),
    .out_tvalid (out_tvalid),
    .out_tready (out_tready)
  );

  task automatic stop_on_error(input string what);
    $display("%s", what);
    $display("TEST FAIL");
    $fatal(1, "Simulation stopped on error");
  endtask

  task automatic load_source(input logic [47:0] mac, input logic [31:0] ip,
                             input logic [15:0] udp);
    write_setting(12'h000, {16'h0, mac[47:32]});
    write_setting(12'h001, mac[31:0]);
    write_setting(12'h002, ip);
    write_setting(12'h003, {16'h0, udp});
    src_mac = mac;
    src_ip  = ip;
    src_udp = udp;
  endtask

  // Local word select comes from regions 4, 5 and 6
  task automatic write_local_entry(input logic [7:0] sid, input logic [31:0] ip,
                                   input logic [15:0] udp, input logic [47:0] mac);
    write_setting({4'd4, sid}, ip);
    write_setting({4'd5, sid}, {udp, mac[47:32]});
    write_setting({4'd6, sid}, mac[31:0]);
    loc_tab[sid] = {ip, udp, mac};
  endtask

  task automatic write_remote_entry(input logic [3:0] idx, input logic [31:0] ip,
                                    input logic [15:0] udp, input logic [47:0] mac);
    write_setting({4'd1, 2'd0, 2'd0, idx}, ip);
    write_setting({4'd1, 2'd1, 2'd0, idx}, {udp, mac[47:32]});
    write_setting({4'd1, 2'd2, 2'd0, idx}, mac[31:0]);
    rem_tab[idx] = {ip, udp, mac};
  endtask

  // CHDR header with random filler around the routed fields, then random payload
  task automatic queue_packet(input logic [15:0] len, input logic [3:0] laddr,
                              input logic [7:0] sid);
    int          n_words;
    int          first;
    logic [63:0] word;
    n_words = (len + 7) / 8;
    first   = in_words.size();
    for (int i = 0; i < n_words; i++)
    begin
      word = {$random(seed), $random(seed)};
      if (i == 0)
      begin
        word[47:32] = len;
        word[11:8]  = laddr;
        word[7:0]   = sid;
      end
      in_words.push_back(word);
      in_lasts.push_back(i == n_words - 1);
    end
    expect_frame(len, laddr, sid, first, n_words);
  endtask

  task automatic run_frames(input int n_frames, input bit backpressure);
    streams_done = 1'b0;
    fork
      send_packet();
      begin
        collect_frame(n_frames);
        streams_done = 1'b1;
      end
      drive_ready(backpressure);
    join
    out_tready = 1'b1;
    check_value("output word count", got_data.size(), exp_data.size());
    for (int i = 0; i < exp_data.size(); i++)
    begin
      check_value($sformatf("out_tdata word %0d", i), got_data[i], exp_data[i]);
      check_value($sformatf("out_tuser word %0d", i), got_user[i], exp_user[i]);
      check_value($sformatf("out_tlast word %0d", i), got_last[i], exp_last[i]);
    end
    in_words.delete();
    in_lasts.delete();
    exp_data.delete();
    exp_user.delete();
    exp_last.delete();
    got_data.delete();
    got_user.delete();
    got_last.delete();
  endtask

  // Source registers are still zero in this first frame
  task automatic check_reset_state();
    @(negedge clk);
    check_value("out_tvalid", out_tvalid, 0);
    check_value("out_tlast", out_tlast, 0);
    check_value("in_tready", in_tready, 0);
    check_value("out_tuser", out_tuser, 0);
    @(posedge clk);
    #1;
    write_local_entry(8'h05, 32'h0A00_0105, 16'd5000, 48'h02_11_22_33_44_55);
    queue_packet(16'd20, 4'd0, 8'h05);
    run_frames(1, 1'b0);
  endtask

  task automatic frame_local_dest();
    load_source(48'h00_50_C2_12_34_56, 32'hC0A8_0A01, 16'd49152);
    write_local_entry(8'h2A, 32'hC0A8_0A2A, 16'd60000, 48'h00_1B_21_AA_BB_CC);
    queue_packet(16'd37, 4'd1, 8'h2A);
    run_frames(1, 1'b0);
  endtask

  task automatic frame_remote_dest();
    write_remote_entry(4'd3, 32'h0A14_1E28, 16'd1234, 48'h00_0C_29_01_02_03);
    queue_packet(16'd50, 4'd3, 8'h2A);
    run_frames(1, 1'b0);
  endtask

  task automatic stress_backpressure();
    queue_packet(16'd24, 4'd0, 8'h05);
    queue_packet(16'd13, 4'd1, 8'h2A);
    queue_packet(16'd64, 4'd3, 8'h2A);
    queue_packet(16'd41, 4'd0, 8'h2A);
    queue_packet(16'd8, 4'd3, 8'h05);
    run_frames(5, 1'b1);
  endtask

  task automatic clear_mid_packet();
    int moved;
    int waited;
    moved      = 0;
    waited     = 0;
    out_tready = 1'b1;
    in_tdata   = {16'h0, 16'd48, 20'h0, 4'd0, 8'h05};
    in_tlast   = 1'b0;
    in_tvalid  = 1'b1;
    // Two payload words pass before the clear
    while (moved < 2)
    begin
      @(negedge clk);
      if (in_tready)
      begin
        moved++;
        @(posedge clk);
        #1;
        in_tdata = {$random(seed), $random(seed)};
      end
      else
      begin
        waited++;
        if (waited > TIMEOUT_CYCLES)
          stop_on_error("Timeout: payload did not start before clear");
        @(posedge clk);
        #1;
      end
    end
    clear = 1'b1;
    @(posedge clk);
    #1;
    clear     = 1'b0;
    in_tvalid = 1'b0;
    @(negedge clk);
    check_value("out_tvalid after clear", out_tvalid, 0);
    check_value("in_tready after clear", in_tready, 0);
    @(posedge clk);
    #1;
    queue_packet(16'd30, 4'd1, 8'h2A);
    run_frames(1, 1'b0);
  endtask

  initial
  begin
    seed         = 32'h5b7b;
    clk          = 1'b0;
    arst_n       = 1'b0;
    clear        = 1'b0;
    set_stb      = 1'b0;
    set_addr     = '0;
    set_data     = '0;
    in_tdata     = '0;
    in_tlast     = 1'b0;
    in_tvalid    = 1'b0;
    out_tready   = 1'b1;
    streams_done = 1'b0;
    src_mac      = '0;
    src_ip       = '0;
    src_udp      = '0;
    repeat (4) @(posedge clk);
    #1;
    arst_n = 1'b1;
    check_reset_state();
    frame_local_dest();
    frame_remote_dest();
    stress_backpressure();
    clear_mid_packet();
    $display("TEST PASS");
    $finish;
  end

endmodule

// File: filelist.f
+incdir+verification
source/framer_pkg.sv
source/framer_settings.sv
source/dest_table.sv
source/ip_checksum.sv
source/chdr_eth_framer.sv
source/eth_framer_top.sv
verification/tb_eth_framer_top.sv

// File: Makefile
# Verilator build and run for the CHDR Ethernet framer testbench

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       ?= tb_eth_framer_top
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# The log decides pass or fail
run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^TEST PASS$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
